//--- list.f
hdl/dvi_pkg.sv
hdl/video_if.sv
hdl/video_timing.sv
hdl/pattern_gen.sv
hdl/ones_counter.sv
hdl/tmds_encoder.sv
hdl/dvi_tx_top.sv
tb/tb_dvi_tx.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -f list.f --top-module tb_dvi_tx -Mdir obj_dir
./obj_dir/Vtb_dvi_tx > sim.log 2>&1 || true
cat sim.log
if grep -q "All checks passed" sim.log; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed, see sim.log"
exit 1

//--- tb/tb_dvi_tx.sv
// Self-checking testbench for the DVI transmitter on the tiny package raster.
// Stops at the first mismatch; mode changes are tracked with their pipeline delay.
module tb_dvi_tx;

    logic                        clk;
    logic                        rst_n;
    logic                        pattern_sel;
    logic [dvi_pkg::SYM_W-1:0]   tmds_r;
    logic [dvi_pkg::SYM_W-1:0]   tmds_g;
    logic [dvi_pkg::SYM_W-1:0]   tmds_b;
    logic                        frame_start;
    integer                      seed;

    dvi_tx_top DUT (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .pattern_sel_i (pattern_sel),
        .tmds_r_o      (tmds_r),
        .tmds_g_o      (tmds_g),
        .tmds_b_o      (tmds_b),
        .frame_start_o (frame_start)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int ones_of(input logic [dvi_pkg::SYM_W-1:0] w);
        int n;
        n = 0;
        for (int i = 0; i < dvi_pkg::SYM_W; i++) begin
            if (w[i]) n++;
        end
        return n;
    endfunction

    function automatic logic is_token(input logic [dvi_pkg::SYM_W-1:0] s);
        return (s == dvi_pkg::CTRL_TOKEN_00) || (s == dvi_pkg::CTRL_TOKEN_01) ||
               (s == dvi_pkg::CTRL_TOKEN_10) || (s == dvi_pkg::CTRL_TOKEN_11);
    endfunction

    function automatic logic in_window(input int pos, input int start, input int len);
        return (pos >= start) && (pos < start + len);
    endfunction

    // Standard DVI 1.0 encoding; disparity is zeroed by any control period.
    function automatic logic [dvi_pkg::SYM_W-1:0] tmds_ref(input logic [7:0] d, input logic de,
                                                          input logic c1, input logic c0,
                                                          inout int disp);
        logic [8:0] qm;
        logic       xnor_sel;
        int         n1d;
        int         n1;
        int         n0;
        if (!de) begin
            disp = 0;
            case ({c1, c0})
                2'b00:   return dvi_pkg::CTRL_TOKEN_00;
                2'b01:   return dvi_pkg::CTRL_TOKEN_01;
                2'b10:   return dvi_pkg::CTRL_TOKEN_10;
                default: return dvi_pkg::CTRL_TOKEN_11;
            endcase
        end
        n1d = ones_of({2'b00, d});
        xnor_sel = (n1d > 4) || ((n1d == 4) && !d[0]);
        qm[0] = d[0];
        for (int i = 1; i < 8; i++) begin
            qm[i] = xnor_sel ? ~(d[i] ^ qm[i-1]) : (d[i] ^ qm[i-1]);
        end
        qm[8] = ~xnor_sel;
        n1 = ones_of({2'b00, qm[7:0]});
        n0 = 8 - n1;
        if ((disp == 0) || (n1 == n0)) begin
            disp = qm[8] ? disp + n1 - n0 : disp + n0 - n1;
            return qm[8] ? {2'b01, qm[7:0]} : {2'b10, ~qm[7:0]};
        end
        if (((disp > 0) && (n1 > n0)) || ((disp < 0) && (n0 > n1))) begin
            disp = disp + (qm[8] ? 2 : 0) + n0 - n1;
            return {1'b1, qm[8], ~qm[7:0]};
        end
        disp = disp - (qm[8] ? 0 : 2) + n1 - n0;
        return {1'b0, qm[8], qm[7:0]};
    endfunction

    function automatic logic [dvi_pkg::PIXEL_W-1:0] lfsr_step(input logic [dvi_pkg::PIXEL_W-1:0] s);
        return {s[dvi_pkg::PIXEL_W-2:0], 1'b0} ^
               ({dvi_pkg::PIXEL_W{s[dvi_pkg::PIXEL_W-1]}} & dvi_pkg::PRBS_TAPS);
    endfunction

    function automatic logic [dvi_pkg::PIXEL_W-1:0] pixel_ref(input logic mode, input int col,
                                                             input logic [dvi_pkg::PIXEL_W-1:0] lfsr);
        logic [2:0] idx;
        idx = 3'(col / int'(dvi_pkg::BAR_W));
        return (mode == dvi_pkg::PAT_BARS) ? dvi_pkg::BAR_COLORS[idx] : lfsr;
    endfunction

    task automatic stop_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_symbol(input logic [dvi_pkg::SYM_W-1:0] got,
                                input logic [dvi_pkg::SYM_W-1:0] exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s, got %h expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("Fail at %0t: %s, got %0d expected %0d", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bound(input int value, input int limit, input string what);
        if ((value > limit) || (value < -limit)) begin
            $display("Fail at %0t: %s, value %0d outside +-%0d", $time, what, value, limit);
            stop_run();
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > 16) begin
                $display("Timeout: reset was never released");
                stop_run();
            end
        end
    endtask

    task automatic wait_frame_start();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > int'(dvi_pkg::H_TOTAL) * int'(dvi_pkg::V_TOTAL) + 8) begin
                $display("Timeout: no frame start pulse from the DUT");
                stop_run();
            end
        end while (!frame_start);
    endtask

    initial begin : stimulus
        int extra;
        seed        = 32'hb37d_c8a7;
        rst_n       = 1'b0;
        pattern_sel = dvi_pkg::PAT_BARS;
        extra       = $random(seed) & 3;
        repeat (3 + extra) @(posedge clk);
        rst_n <= 1'b1;
        // Two bar frames, then two PRBS frames.
        for (int f = 1; f <= 5; f++) begin
            wait_frame_start();
            if (f == 3) pattern_sel <= dvi_pkg::PAT_PRBS;
        end
        @(negedge clk);
        $display("All checks passed");
        $finish;
    end

    initial begin : compare_proc
        int                          h;
        int                          v;
        int                          frame_cycles;
        int                          data_lines;
        int                          line_data [3];
        int                          line_bal [3];
        int                          disp [3];
        logic [dvi_pkg::SYM_W-1:0]   sym [3];
        logic [dvi_pkg::SYM_W-1:0]   exp_sym;
        logic [dvi_pkg::PIXEL_W-1:0] lfsr;
        logic [dvi_pkg::PIXEL_W-1:0] pix;
        logic [7:0]                  byte_in;
        logic [2:0]                  sel_hist;
        logic                        mode;
        logic                        active;
        logic                        hs;
        logic                        vs;
        logic                        started;
        h = 0;
        v = 0;
        frame_cycles = 0;
        data_lines = 0;
        lfsr = dvi_pkg::PRBS_SEED;
        sel_hist = {3{dvi_pkg::PAT_BARS}};
        started = 1'b0;
        for (int ch = 0; ch < 3; ch++) begin
            line_data[ch] = 0;
            line_bal[ch] = 0;
            disp[ch] = 0;
        end
        wait_reset_release();
        check_symbol(tmds_b, '0, "blue at reset release");
        check_symbol(tmds_g, '0, "green at reset release");
        check_symbol(tmds_r, '0, "red at reset release");
        forever begin
            @(negedge clk);
            sym[0] = tmds_b;
            sym[1] = tmds_g;
            sym[2] = tmds_r;
            // Pattern select reaches the symbols three clocks later.
            mode = sel_hist[2];
            sel_hist = {sel_hist[1:0], pattern_sel};
            if (frame_start) begin
                if (started) begin
                    check_count(frame_cycles, int'(dvi_pkg::H_TOTAL) * int'(dvi_pkg::V_TOTAL),
                                "cycles between frame starts");
                    check_count(data_lines, int'(dvi_pkg::V_ACTIVE), "lines with data");
                end
                started = 1'b1;
                h = 0;
                v = 0;
                frame_cycles = 0;
                data_lines = 0;
            end
            if (!started) begin
                // Syncs are deasserted while the pipeline fills.
                for (int ch = 0; ch < 3; ch++) begin
                    exp_sym = tmds_ref(8'h00, 1'b0,
                                       (ch == 0) ? ~dvi_pkg::VSYNC_POL : dvi_pkg::CTRL_IDLE,
                                       (ch == 0) ? ~dvi_pkg::HSYNC_POL : dvi_pkg::CTRL_IDLE,
                                       disp[ch]);
                    check_symbol(sym[ch], exp_sym, $sformatf("ch %0d pipeline fill", ch));
                end
            end else begin
                active = (h < int'(dvi_pkg::H_ACTIVE)) && (v < int'(dvi_pkg::V_ACTIVE));
                hs = in_window(h, int'(dvi_pkg::H_ACTIVE) + int'(dvi_pkg::H_FRONT),
                               int'(dvi_pkg::H_SYNC)) ? dvi_pkg::HSYNC_POL : ~dvi_pkg::HSYNC_POL;
                vs = in_window(v, int'(dvi_pkg::V_ACTIVE) + int'(dvi_pkg::V_FRONT),
                               int'(dvi_pkg::V_SYNC)) ? dvi_pkg::VSYNC_POL : ~dvi_pkg::VSYNC_POL;
                pix = '0;
                if (active) begin
                    if ((h == 0) && (v == 0)) lfsr = dvi_pkg::PRBS_SEED;
                    pix = pixel_ref(mode, h, lfsr);
                    lfsr = lfsr_step(lfsr);
                end
                for (int ch = 0; ch < 3; ch++) begin
                    byte_in = pix[8*ch +: 8];
                    exp_sym = tmds_ref(byte_in, active, (ch == 0) ? vs : dvi_pkg::CTRL_IDLE,
                                       (ch == 0) ? hs : dvi_pkg::CTRL_IDLE, disp[ch]);
                    check_symbol(sym[ch], exp_sym,
                                 $sformatf("ch %0d col %0d line %0d", ch, h, v));
                    if (!is_token(sym[ch])) begin
                        line_data[ch]++;
                        line_bal[ch] += 2 * ones_of(sym[ch]) - dvi_pkg::SYM_W;
                        check_bound(line_bal[ch], 10, $sformatf("ch %0d line balance", ch));
                    end
                end
                if (h == int'(dvi_pkg::H_TOTAL) - 1) begin
                    for (int ch = 0; ch < 3; ch++) begin
                        check_count(line_data[ch],
                                    (v < int'(dvi_pkg::V_ACTIVE)) ? int'(dvi_pkg::H_ACTIVE) : 0,
                                    $sformatf("ch %0d data symbols in line %0d", ch, v));
                    end
                    if (line_data[0] > 0) data_lines++;
                    for (int ch = 0; ch < 3; ch++) begin
                        line_data[ch] = 0;
                        line_bal[ch] = 0;
                    end
                end
                frame_cycles++;
                h++;
                if (h == int'(dvi_pkg::H_TOTAL)) begin
                    h = 0;
                    v = (v + 1) % int'(dvi_pkg::V_TOTAL);
                end
            end
        end
    end

endmodule

//--- hdl/dvi_tx_top.sv
// Symbols appear four clocks after the raster counter state that made them.
// Only blue carries syncs; green and red send the idle control token.
module dvi_tx_top (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      pattern_sel_i,
    output logic [dvi_pkg::SYM_W-1:0] tmds_r_o,
    output logic [dvi_pkg::SYM_W-1:0] tmds_g_o,
    output logic [dvi_pkg::SYM_W-1:0] tmds_b_o,
    output logic                      frame_start_o
);

    logic                      tim_de;
    logic                      tim_hsync;
    logic                      tim_vsync;
    logic [dvi_pkg::COL_W-1:0] tim_col;
    logic                      tim_frame_start;
    logic                      pix_frame_start;
    logic                      enc_frame_start;

    video_if vid ();

    video_timing u_timing (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .de_o          (tim_de),
        .hsync_o       (tim_hsync),
        .vsync_o       (tim_vsync),
        .col_o         (tim_col),
        .frame_start_o (tim_frame_start)
    );

    pattern_gen u_pattern (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .pattern_sel_i (pattern_sel_i),
        .de_i          (tim_de),
        .hsync_i       (tim_hsync),
        .vsync_i       (tim_vsync),
        .col_i         (tim_col),
        .frame_start_i (tim_frame_start),
        .frame_start_o (pix_frame_start),
        .vid           (vid.source)
    );

    tmds_encoder u_enc_b (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .de_i    (vid.de),
        .c1_i    (vid.vsync),
        .c0_i    (vid.hsync),
        .d_i     (vid.b),
        .q_o     (tmds_b_o)
    );

    tmds_encoder u_enc_g (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .de_i    (vid.de),
        .c1_i    (dvi_pkg::CTRL_IDLE),
        .c0_i    (dvi_pkg::CTRL_IDLE),
        .d_i     (vid.g),
        .q_o     (tmds_g_o)
    );

    tmds_encoder u_enc_r (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .de_i    (vid.de),
        .c1_i    (dvi_pkg::CTRL_IDLE),
        .c0_i    (dvi_pkg::CTRL_IDLE),
        .d_i     (vid.r),
        .q_o     (tmds_r_o)
    );

    // Matches the two encoder stages.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            enc_frame_start <= 1'b0;
            frame_start_o   <= 1'b0;
        end else begin
            enc_frame_start <= pix_frame_start;
            frame_start_o   <= enc_frame_start;
        end
    end

endmodule

//--- hdl/tmds_encoder.sv
// Two clocks from inputs to symbol. Disparity restarts at zero after any
// control period, so the first data symbol of a line sees a balanced link.
module tmds_encoder (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        de_i,
    input  logic                        c1_i,
    input  logic                        c0_i,
    input  logic [dvi_pkg::COLOR_W-1:0] d_i,
    output logic [dvi_pkg::SYM_W-1:0]   q_o
);

    logic [dvi_pkg::ONES_W-1:0]       n_d;
    logic [dvi_pkg::ONES_W-1:0]       n_1;
    logic [dvi_pkg::ONES_W-1:0]       n_0;
    logic                             use_xnor;
    logic [dvi_pkg::COLOR_W:0]        q_m;
    logic [dvi_pkg::COLOR_W:0]        q_r;
    logic                             de_r;
    logic                             c1_r;
    logic                             c0_r;
    logic signed [dvi_pkg::DISP_W-1:0] disp;
    logic signed [dvi_pkg::DISP_W-1:0] disp_next;
    logic signed [dvi_pkg::DISP_W-1:0] bal;
    logic signed [dvi_pkg::DISP_W-1:0] two_q8;
    logic signed [dvi_pkg::DISP_W-1:0] two_nq8;
    logic                             disp_pos;
    logic                             disp_neg;
    logic [dvi_pkg::SYM_W-1:0]        q_next;

    ones_counter u_cnt_d (
        .data_i  (d_i),
        .count_o (n_d)
    );

    ones_counter u_cnt_ones (
        .data_i  (q_r[dvi_pkg::COLOR_W-1:0]),
        .count_o (n_1)
    );

    ones_counter u_cnt_zeros (
        .data_i  (~q_r[dvi_pkg::COLOR_W-1:0]),
        .count_o (n_0)
    );

    // Stage one, transition minimisation.
    assign use_xnor = (n_d > 4'd4) || ((n_d == 4'd4) && !d_i[0]);

    always_comb begin
        q_m[0] = d_i[0];
        for (int i = 1; i < dvi_pkg::COLOR_W; i++) begin
            q_m[i] = use_xnor ? ~(d_i[i] ^ q_m[i-1]) : (d_i[i] ^ q_m[i-1]);
        end
        q_m[dvi_pkg::COLOR_W] = ~use_xnor;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            de_r <= 1'b0;
            c1_r <= 1'b0;
            c0_r <= 1'b0;
        end else begin
            de_r <= de_i;
            c1_r <= c1_i;
            c0_r <= c0_i;
        end
    end

    always_ff @(posedge clk_i) begin
        q_r <= q_m;
    end

    // Stage two, DC balance.
    assign bal      = $signed({1'b0, n_1}) - $signed({1'b0, n_0});
    assign two_q8   = {{(dvi_pkg::DISP_W-2){1'b0}}, q_r[8], 1'b0};
    assign two_nq8  = {{(dvi_pkg::DISP_W-2){1'b0}}, ~q_r[8], 1'b0};
    assign disp_neg = disp[dvi_pkg::DISP_W-1];
    assign disp_pos = !disp_neg && (disp != '0);

    always_comb begin
        if (!de_r) begin
            disp_next = '0;
            case ({c1_r, c0_r})
                2'b00:   q_next = dvi_pkg::CTRL_TOKEN_00;
                2'b01:   q_next = dvi_pkg::CTRL_TOKEN_01;
                2'b10:   q_next = dvi_pkg::CTRL_TOKEN_10;
                default: q_next = dvi_pkg::CTRL_TOKEN_11;
            endcase
        end else if ((disp == '0) || (n_1 == n_0)) begin
            q_next    = {~q_r[8], q_r[8], q_r[8] ? q_r[7:0] : ~q_r[7:0]};
            disp_next = q_r[8] ? disp + bal : disp - bal;
        end else if ((disp_pos && (n_1 > n_0)) || (disp_neg && (n_0 > n_1))) begin
            q_next    = {1'b1, q_r[8], ~q_r[7:0]};
            disp_next = disp + two_q8 - bal;
        end else begin
            q_next    = {1'b0, q_r[8], q_r[7:0]};
            disp_next = disp - two_nq8 + bal;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            disp <= '0;
            q_o  <= '0;
        end else begin
            disp <= disp_next;
            q_o  <= q_next;
        end
    end

endmodule

//--- hdl/ones_counter.sv
// Purely combinational, so it adds to the delay of the stage that uses it.
module ones_counter (
    input  logic [dvi_pkg::COLOR_W-1:0] data_i,
    output logic [dvi_pkg::ONES_W-1:0]  count_o
);

    logic [1:0] pair_sum [dvi_pkg::COLOR_W/2];
    logic [2:0] quad_lo;
    logic [2:0] quad_hi;

    // Level one adds neighbouring bits.
    for (genvar i = 0; i < dvi_pkg::COLOR_W / 2; i++) begin : g_pair
        assign pair_sum[i] = {1'b0, data_i[2*i]} + {1'b0, data_i[2*i+1]};
    end

    // Level two folds the pairs into the total.
    assign quad_lo = {1'b0, pair_sum[0]} + {1'b0, pair_sum[1]};
    assign quad_hi = {1'b0, pair_sum[2]} + {1'b0, pair_sum[3]};
    assign count_o = {1'b0, quad_lo} + {1'b0, quad_hi};

endmodule

//--- hdl/pattern_gen.sv
// One clock from timing inputs to the video word; syncs are delayed to match.
// The LFSR steps on every active pixel in either mode.
module pattern_gen (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      pattern_sel_i,
    input  logic                      de_i,
    input  logic                      hsync_i,
    input  logic                      vsync_i,
    input  logic [dvi_pkg::COL_W-1:0] col_i,
    input  logic                      frame_start_i,
    output logic                      frame_start_o,
    video_if.source                   vid
);

    logic [dvi_pkg::PIXEL_W-1:0]   lfsr_q;
    logic [dvi_pkg::PIXEL_W-1:0]   lfsr_cur;
    logic [dvi_pkg::PIXEL_W-1:0]   lfsr_next;
    logic [dvi_pkg::COL_W-1:0]     bar_full;
    logic [dvi_pkg::BAR_IDX_W-1:0] bar_idx;
    logic [dvi_pkg::PIXEL_W-1:0]   pixel;

    assign bar_full = col_i / dvi_pkg::BAR_W;
    assign bar_idx  = bar_full[dvi_pkg::BAR_IDX_W-1:0];

    always_comb begin
        // Seed is the first pixel of every frame.
        lfsr_cur  = frame_start_i ? dvi_pkg::PRBS_SEED : lfsr_q;
        lfsr_next = {lfsr_cur[dvi_pkg::PIXEL_W-2:0], 1'b0} ^
                    ({dvi_pkg::PIXEL_W{lfsr_cur[dvi_pkg::PIXEL_W-1]}} & dvi_pkg::PRBS_TAPS);
        pixel     = (pattern_sel_i == dvi_pkg::PAT_BARS) ? dvi_pkg::BAR_COLORS[bar_idx]
                                                          : lfsr_cur;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            lfsr_q        <= dvi_pkg::PRBS_SEED;
            vid.de        <= 1'b0;
            vid.hsync     <= ~dvi_pkg::HSYNC_POL;
            vid.vsync     <= ~dvi_pkg::VSYNC_POL;
            frame_start_o <= 1'b0;
        end else begin
            if (de_i) begin
                lfsr_q <= lfsr_next;
            end
            vid.de        <= de_i;
            vid.hsync     <= hsync_i;
            vid.vsync     <= vsync_i;
            frame_start_o <= frame_start_i;
        end
    end

    // Colour is forced to black in blanking.
    always_ff @(posedge clk_i) begin
        {vid.r, vid.g, vid.b} <= de_i ? pixel : '0;
    end

endmodule

//--- hdl/video_timing.sv
// Outputs are registered and lag the counter state by one clock.
// Sync windows sit right after the front porch of each line and frame.
module video_timing (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    output logic                      de_o,
    output logic                      hsync_o,
    output logic                      vsync_o,
    output logic [dvi_pkg::COL_W-1:0] col_o,
    output logic                      frame_start_o
);

    logic [dvi_pkg::H_CNT_W-1:0] h_cnt;
    logic [dvi_pkg::V_CNT_W-1:0] v_cnt;
    logic                        h_last;
    logic                        v_last;
    logic                        h_active;
    logic                        v_active;
    logic                        h_sync_win;
    logic                        v_sync_win;

    assign h_last = (h_cnt == dvi_pkg::H_TOTAL - 1'b1);
    assign v_last = (v_cnt == dvi_pkg::V_TOTAL - 1'b1);

    assign h_active = (h_cnt < dvi_pkg::H_ACTIVE);
    assign v_active = (v_cnt < dvi_pkg::V_ACTIVE);

    assign h_sync_win = (h_cnt >= dvi_pkg::H_ACTIVE + dvi_pkg::H_FRONT) &&
                        (h_cnt <  dvi_pkg::H_ACTIVE + dvi_pkg::H_FRONT + dvi_pkg::H_SYNC);
    assign v_sync_win = (v_cnt >= dvi_pkg::V_ACTIVE + dvi_pkg::V_FRONT) &&
                        (v_cnt <  dvi_pkg::V_ACTIVE + dvi_pkg::V_FRONT + dvi_pkg::V_SYNC);

    // Raster counters.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
            v_cnt <= v_last ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            de_o          <= 1'b0;
            hsync_o       <= ~dvi_pkg::HSYNC_POL;
            vsync_o       <= ~dvi_pkg::VSYNC_POL;
            col_o         <= '0;
            frame_start_o <= 1'b0;
        end else begin
            de_o          <= h_active && v_active;
            hsync_o       <= h_sync_win ? dvi_pkg::HSYNC_POL : ~dvi_pkg::HSYNC_POL;
            vsync_o       <= v_sync_win ? dvi_pkg::VSYNC_POL : ~dvi_pkg::VSYNC_POL;
            col_o         <= h_cnt;
            // First active pixel of the frame.
            frame_start_o <= (h_cnt == '0) && (v_cnt == '0);
        end
    end

endmodule

//--- hdl/video_if.sv
// Plain levels, all valid on every pixel clock; there is no handshake.
interface video_if;

    logic                       de;
    logic                       hsync;
    logic                       vsync;
    logic [dvi_pkg::COLOR_W-1:0] r;
    logic [dvi_pkg::COLOR_W-1:0] g;
    logic [dvi_pkg::COLOR_W-1:0] b;

    modport source (
        output de, hsync, vsync,
        output r, g, b
    );

    modport sink (
        input de, hsync, vsync,
        input r, g, b
    );

endinterface

//--- hdl/dvi_pkg.sv
// Video timing is a tiny test raster, far below any real DVI mode.
// Timing constants are sized to the counter widths and must fit in them.
package dvi_pkg;

    localparam int SYM_W   = 10;
    localparam int COLOR_W = 8;
    localparam int PIXEL_W = 3 * COLOR_W;
    localparam int ONES_W  = 4;
    localparam int DISP_W  = ONES_W + 1;

    localparam int H_CNT_W = 5;
    localparam int V_CNT_W = 4;
    localparam int COL_W   = H_CNT_W;

    localparam logic [H_CNT_W-1:0] H_ACTIVE = 5'd16;
    localparam logic [H_CNT_W-1:0] H_FRONT  = 5'd2;
    localparam logic [H_CNT_W-1:0] H_SYNC   = 5'd4;
    localparam logic [H_CNT_W-1:0] H_BACK   = 5'd3;
    localparam logic [H_CNT_W-1:0] H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

    localparam logic [V_CNT_W-1:0] V_ACTIVE = 4'd4;
    localparam logic [V_CNT_W-1:0] V_FRONT  = 4'd1;
    localparam logic [V_CNT_W-1:0] V_SYNC   = 4'd2;
    localparam logic [V_CNT_W-1:0] V_BACK   = 4'd1;
    localparam logic [V_CNT_W-1:0] V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    localparam logic HSYNC_POL = 1'b1;
    localparam logic VSYNC_POL = 1'b1;
    localparam logic CTRL_IDLE = 1'b0;

    // Control symbols, indexed by {c1, c0}.
    localparam logic [SYM_W-1:0] CTRL_TOKEN_00 = 10'b11_0101_0100;
    localparam logic [SYM_W-1:0] CTRL_TOKEN_01 = 10'b00_1010_1011;
    localparam logic [SYM_W-1:0] CTRL_TOKEN_10 = 10'b01_0101_0100;
    localparam logic [SYM_W-1:0] CTRL_TOKEN_11 = 10'b10_1010_1011;

    localparam int BAR_COUNT = 8;
    localparam int BAR_IDX_W = $clog2(BAR_COUNT);
    localparam logic [COL_W-1:0] BAR_W = 5'd2;

    // Bars in {R, G, B} order: white, yellow, cyan, green, magenta, red, blue, black.
    localparam logic [0:BAR_COUNT-1][PIXEL_W-1:0] BAR_COLORS = {
        24'hFFFFFF, 24'hFFFF00, 24'h00FFFF, 24'h00FF00,
        24'hFF00FF, 24'hFF0000, 24'h0000FF, 24'h000000
    };

    // Galois LFSR for x^24 + x^23 + x^22 + x^17 + 1.
    localparam logic [PIXEL_W-1:0] PRBS_SEED = 24'h5AC396;
    localparam logic [PIXEL_W-1:0] PRBS_TAPS = 24'hC20001;

    localparam logic PAT_BARS = 1'b0;
    localparam logic PAT_PRBS = 1'b1;

endpackage
